// File: cbuf_geom_pkg.sv
// ==================================================
// storage geometry shared by every cbuf block
// one RAM per bank, bank word equals client word
// ==================================================
package cbuf_geom_pkg;

  // bits per bank word, also the width of each client data port
  localparam int RAM_WIDTH = 64;

  // one bank word or one client data word
  typedef logic [RAM_WIDTH-1:0] cbuf_data_t;

  // default geometry, the top level may override both
  localparam int DEFAULT_NUM_BANKS       = 4;
  localparam int DEFAULT_BANK_DEPTH_BITS = 4;

  // bank words ORed together per level of the read tree
  // bank count has to be a power of this
  localparam int GROUP_FANIN = 4;

endpackage

// File: cbuf_client_pkg.sv
// ==================================================
// pipeline depths seen by the read and write clients
// read latency is 3 plus the number of tree levels
// ==================================================
package cbuf_client_pkg;

  // registered read enable and row in front of the RAMs
  localparam int RD_CTRL_STAGES = 1;

  // RAM read latency
  localparam int RAM_RD_STAGES = 1;

  // flop right after masking, first tree level
  localparam int RD_MASK_STAGES = 1;

  // write pipeline in front of the RAMs (d1, d2)
  localparam int WR_STAGES = 2;

endpackage

// File: cbuf_bank_ram.sv
// ==================================================
// one bank, 1R1W synchronous RAM
// same row read and written at one edge gives old word
// no reset on contents or read data
// ==================================================
`timescale 1ns/1ps

module cbuf_bank_ram #(
  parameter int BANK_DEPTH_BITS = cbuf_geom_pkg::DEFAULT_BANK_DEPTH_BITS
) (
  input  logic                       nvdla_core_clk,
  input  logic                       re,
  input  logic [BANK_DEPTH_BITS-1:0] ra,
  input  logic                       we,
  input  logic [BANK_DEPTH_BITS-1:0] wa,
  input  cbuf_geom_pkg::cbuf_data_t  di,
  output cbuf_geom_pkg::cbuf_data_t  dout
);

  localparam int DEPTH = 1 << BANK_DEPTH_BITS;

  cbuf_geom_pkg::cbuf_data_t mem [DEPTH];

  // write port
  always_ff @(posedge nvdla_core_clk) begin
    if (we) begin
      mem[wa] <= di;
    end
  end

  // read port, dout holds while re is low
  always_ff @(posedge nvdla_core_clk) begin
    if (re) begin
      dout <= mem[ra];
    end
  end

endmodule

// File: cbuf_write_path.sv
// ==================================================
// write decode for the data and weight clients
// two flop stages, RAM stores at the third edge
// both clients on one bank in one cycle is illegal
// ==================================================
`timescale 1ns/1ps

module cbuf_write_path #(
  parameter int  NUM_BANKS       = cbuf_geom_pkg::DEFAULT_NUM_BANKS,
  parameter int  BANK_DEPTH_BITS = cbuf_geom_pkg::DEFAULT_BANK_DEPTH_BITS,
  localparam int BANK_BITS       = $clog2(NUM_BANKS),
  localparam int ADDR_W          = BANK_BITS + BANK_DEPTH_BITS
) (
  input  logic                                      nvdla_core_clk,
  input  logic                                      rst_n,
  input  logic                                      dat_wr_en,
  input  logic [ADDR_W-1:0]                         dat_wr_addr,
  input  cbuf_geom_pkg::cbuf_data_t                 dat_wr_data,
  input  logic                                      wt_wr_en,
  input  logic [ADDR_W-1:0]                         wt_wr_addr,
  input  cbuf_geom_pkg::cbuf_data_t                 wt_wr_data,
  output logic [NUM_BANKS-1:0]                      bank_wr_en,
  output logic [NUM_BANKS-1:0][BANK_DEPTH_BITS-1:0] bank_wr_row,
  output cbuf_geom_pkg::cbuf_data_t [NUM_BANKS-1:0] bank_wr_data
);

  // client 0 is feature data, client 1 is weight
  localparam int NUM_CLIENTS = 2;

  logic [NUM_CLIENTS-1:0]                      wr_en;
  logic [NUM_CLIENTS-1:0][ADDR_W-1:0]          wr_addr;
  cbuf_geom_pkg::cbuf_data_t [NUM_CLIENTS-1:0] wr_data;
  logic [NUM_CLIENTS-1:0][NUM_BANKS-1:0]       hit_d0;
  logic [NUM_CLIENTS-1:0][NUM_BANKS-1:0]       hit_d1;
  logic [NUM_CLIENTS-1:0][BANK_DEPTH_BITS-1:0] row_d1;
  cbuf_geom_pkg::cbuf_data_t [NUM_CLIENTS-1:0] data_d1;

  assign wr_en   = {wt_wr_en, dat_wr_en};
  assign wr_addr = {wt_wr_addr, dat_wr_addr};
  assign wr_data = {wt_wr_data, dat_wr_data};

  // one-hot bank hit per client, upper address bits pick the bank
  always_comb begin
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      hit_d0[c] = {{(NUM_BANKS-1){1'b0}}, wr_en[c]} << wr_addr[c][ADDR_W-1 -: BANK_BITS];
    end
  end

  // ==================================================
  // d1: per-client stage
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      hit_d1 <= '0;
    end else begin
      hit_d1 <= hit_d0;
    end
  end

  // row and data only move on a write
  always_ff @(posedge nvdla_core_clk) begin
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      if (wr_en[c]) begin
        row_d1[c]  <= wr_addr[c][BANK_DEPTH_BITS-1:0];
        data_d1[c] <= wr_data[c];
      end
    end
  end

  // ==================================================
  // d2: per-bank stage, the one client hitting a bank wins
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      bank_wr_en <= '0;
    end else begin
      bank_wr_en <= hit_d1[0] | hit_d1[1];
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (hit_d1[1][b]) begin
        bank_wr_row[b]  <= row_d1[1];
        bank_wr_data[b] <= data_d1[1];
      end else if (hit_d1[0][b]) begin
        bank_wr_row[b]  <= row_d1[0];
        bank_wr_data[b] <= data_d1[0];
      end
    end
  end

  // feature and weight writes never share a bank
  a_wr_no_collision: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    (hit_d0[0] & hit_d0[1]) == '0)
    else $error("data and weight writes hit one bank in the same cycle");

endmodule

// File: cbuf_read_decode.sv
// ==================================================
// read decode for one client
// bank_sel_d2 lines up with the RAM output
// ==================================================
`timescale 1ns/1ps

module cbuf_read_decode #(
  parameter int  NUM_BANKS       = cbuf_geom_pkg::DEFAULT_NUM_BANKS,
  parameter int  BANK_DEPTH_BITS = cbuf_geom_pkg::DEFAULT_BANK_DEPTH_BITS,
  localparam int BANK_BITS       = $clog2(NUM_BANKS),
  localparam int ADDR_W          = BANK_BITS + BANK_DEPTH_BITS
) (
  input  logic                                      nvdla_core_clk,
  input  logic                                      rst_n,
  input  logic                                      rd_en,
  input  logic [ADDR_W-1:0]                         rd_addr,
  output logic [NUM_BANKS-1:0]                      bank_rd_en,
  output logic [NUM_BANKS-1:0][BANK_DEPTH_BITS-1:0] bank_rd_row,
  output logic [NUM_BANKS-1:0]                      bank_sel_d2
);

  // select rides along the read control flop and the RAM read
  localparam int SEL_DLY = cbuf_client_pkg::RD_CTRL_STAGES + cbuf_client_pkg::RAM_RD_STAGES;

  logic [SEL_DLY-1:0][NUM_BANKS-1:0] sel_q;

  // one-hot bank enable
  assign bank_rd_en = {{(NUM_BANKS-1){1'b0}}, rd_en} << rd_addr[ADDR_W-1 -: BANK_BITS];

  // same row offered to every bank, the enable decides who uses it
  assign bank_rd_row = {NUM_BANKS{rd_addr[BANK_DEPTH_BITS-1:0]}};

  // select delay line
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= '0;
    end else begin
      sel_q[0] <= bank_rd_en;
      for (int i = 1; i < SEL_DLY; i++) begin
        sel_q[i] <= sel_q[i-1];
      end
    end
  end

  assign bank_sel_d2 = sel_q[SEL_DLY-1];

endmodule

// File: cbuf_bank_array.sv
// ==================================================
// all RAM banks plus the registered read control
// data and weight reads must not share a bank
// an unread bank keeps its last output
// ==================================================
`timescale 1ns/1ps

module cbuf_bank_array #(
  parameter int NUM_BANKS       = cbuf_geom_pkg::DEFAULT_NUM_BANKS,
  parameter int BANK_DEPTH_BITS = cbuf_geom_pkg::DEFAULT_BANK_DEPTH_BITS
) (
  input  logic                                      nvdla_core_clk,
  input  logic                                      rst_n,
  input  logic [NUM_BANKS-1:0]                      dat_bank_rd_en,
  input  logic [NUM_BANKS-1:0][BANK_DEPTH_BITS-1:0] dat_bank_rd_row,
  input  logic [NUM_BANKS-1:0]                      wt_bank_rd_en,
  input  logic [NUM_BANKS-1:0][BANK_DEPTH_BITS-1:0] wt_bank_rd_row,
  input  logic [NUM_BANKS-1:0]                      bank_wr_en,
  input  logic [NUM_BANKS-1:0][BANK_DEPTH_BITS-1:0] bank_wr_row,
  input  cbuf_geom_pkg::cbuf_data_t [NUM_BANKS-1:0] bank_wr_data,
  output cbuf_geom_pkg::cbuf_data_t [NUM_BANKS-1:0] bank_rd_data
);

  logic [NUM_BANKS-1:0]                      rd_en_d1;
  logic [NUM_BANKS-1:0][BANK_DEPTH_BITS-1:0] rd_row_d1;

  // ==================================================
  // read control stage
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en_d1 <= '0;
    end else begin
      rd_en_d1 <= dat_bank_rd_en | wt_bank_rd_en;
    end
  end

  // row of the requesting client, held when idle
  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (wt_bank_rd_en[b]) begin
        rd_row_d1[b] <= wt_bank_rd_row[b];
      end else if (dat_bank_rd_en[b]) begin
        rd_row_d1[b] <= dat_bank_rd_row[b];
      end
    end
  end

  // ==================================================
  // banks
  // ==================================================
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    cbuf_bank_ram #(
      .BANK_DEPTH_BITS (BANK_DEPTH_BITS)
    ) u_ram (
      .nvdla_core_clk (nvdla_core_clk),
      .re             (rd_en_d1[b]),
      .ra             (rd_row_d1[b]),
      .we             (bank_wr_en[b]),
      .wa             (bank_wr_row[b]),
      .di             (bank_wr_data[b]),
      .dout           (bank_rd_data[b])
    );
  end

  // the two read decoders never pick the same bank
  a_rd_no_collision: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    (dat_bank_rd_en & wt_bank_rd_en) == '0)
    else $error("data and weight reads hit one bank in the same cycle");

endmodule

// File: cbuf_read_collect.sv
// ==================================================
// masks bank outputs for one client, ORs them down
// a flop per level, valid delayed to match the data
// bank count must be a power of the group fan-in
// ==================================================
`timescale 1ns/1ps

module cbuf_read_collect #(
  parameter int NUM_BANKS = cbuf_geom_pkg::DEFAULT_NUM_BANKS
) (
  input  logic                                      nvdla_core_clk,
  input  logic                                      rst_n,
  input  logic [NUM_BANKS-1:0]                      bank_sel_d2,
  input  cbuf_geom_pkg::cbuf_data_t [NUM_BANKS-1:0] bank_rd_data,
  output logic                                      rd_valid,
  output cbuf_geom_pkg::cbuf_data_t                 rd_data
);

  localparam int FANIN   = cbuf_geom_pkg::GROUP_FANIN;
  localparam int LEVELS  = $clog2(NUM_BANKS) / $clog2(FANIN);
  localparam int VLD_DLY = cbuf_client_pkg::RD_MASK_STAGES + LEVELS;

  logic [VLD_DLY-1:0] vld_q;

  // ==================================================
  // data tree, g_lvl[0] is the masked flop
  // ==================================================
  for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
    localparam int N = NUM_BANKS / (FANIN ** l);

    cbuf_geom_pkg::cbuf_data_t [N-1:0] q;

    if (l == 0) begin : g_mask
      // zero every bank this client did not read
      always_ff @(posedge nvdla_core_clk) begin
        for (int i = 0; i < N; i++) begin
          q[i] <= bank_rd_data[i] & {cbuf_geom_pkg::RAM_WIDTH{bank_sel_d2[i]}};
        end
      end
    end else begin : g_or
      cbuf_geom_pkg::cbuf_data_t [N-1:0] or_w;

      // group of FANIN words from the level below
      always_comb begin
        for (int i = 0; i < N; i++) begin
          or_w[i] = '0;
          for (int k = 0; k < FANIN; k++) begin
            or_w[i] = or_w[i] | g_lvl[l-1].q[i*FANIN+k];
          end
        end
      end

      always_ff @(posedge nvdla_core_clk) begin
        q <= or_w;
      end
    end
  end

  assign rd_data = g_lvl[LEVELS].q[0];

  // ==================================================
  // valid, same depth as the tree
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[VLD_DLY-2:0], |bank_sel_d2};
    end
  end

  assign rd_valid = vld_q[VLD_DLY-1];

  // one client reads one bank per request
  a_sel_onehot: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    $onehot0(bank_sel_d2))
    else $error("more than one bank selected for one client");

endmodule

// File: cbuf_top.sv
// ==================================================
// banked convolution buffer, 2 write and 2 read clients
// read valid after 3 plus tree levels cycles
// no stall, bank collisions are illegal
// ==================================================
`timescale 1ns/1ps

module cbuf_top #(
  parameter int  NUM_BANKS       = cbuf_geom_pkg::DEFAULT_NUM_BANKS,
  parameter int  BANK_DEPTH_BITS = cbuf_geom_pkg::DEFAULT_BANK_DEPTH_BITS,
  localparam int ADDR_W          = $clog2(NUM_BANKS) + BANK_DEPTH_BITS
) (
  input  logic                      nvdla_core_clk,
  input  logic                      rst_n,
  input  logic                      cdma2buf_dat_wr_en,
  input  logic [ADDR_W-1:0]         cdma2buf_dat_wr_addr,
  input  cbuf_geom_pkg::cbuf_data_t cdma2buf_dat_wr_data,
  input  logic                      cdma2buf_wt_wr_en,
  input  logic [ADDR_W-1:0]         cdma2buf_wt_wr_addr,
  input  cbuf_geom_pkg::cbuf_data_t cdma2buf_wt_wr_data,
  input  logic                      sc2buf_dat_rd_en,
  input  logic [ADDR_W-1:0]         sc2buf_dat_rd_addr,
  output logic                      sc2buf_dat_rd_valid,
  output cbuf_geom_pkg::cbuf_data_t sc2buf_dat_rd_data,
  input  logic                      sc2buf_wt_rd_en,
  input  logic [ADDR_W-1:0]         sc2buf_wt_rd_addr,
  output logic                      sc2buf_wt_rd_valid,
  output cbuf_geom_pkg::cbuf_data_t sc2buf_wt_rd_data
);

  // write path to banks
  logic [NUM_BANKS-1:0]                      bank_wr_en;
  logic [NUM_BANKS-1:0][BANK_DEPTH_BITS-1:0] bank_wr_row;
  cbuf_geom_pkg::cbuf_data_t [NUM_BANKS-1:0] bank_wr_data;

  // read decoders to banks and collectors
  logic [NUM_BANKS-1:0]                      dat_bank_rd_en;
  logic [NUM_BANKS-1:0][BANK_DEPTH_BITS-1:0] dat_bank_rd_row;
  logic [NUM_BANKS-1:0]                      dat_bank_sel_d2;
  logic [NUM_BANKS-1:0]                      wt_bank_rd_en;
  logic [NUM_BANKS-1:0][BANK_DEPTH_BITS-1:0] wt_bank_rd_row;
  logic [NUM_BANKS-1:0]                      wt_bank_sel_d2;

  // raw bank outputs, shared by both collectors
  cbuf_geom_pkg::cbuf_data_t [NUM_BANKS-1:0] bank_rd_data;

  cbuf_write_path #(
    .NUM_BANKS       (NUM_BANKS),
    .BANK_DEPTH_BITS (BANK_DEPTH_BITS)
  ) u_write_path (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .dat_wr_en      (cdma2buf_dat_wr_en),
    .dat_wr_addr    (cdma2buf_dat_wr_addr),
    .dat_wr_data    (cdma2buf_dat_wr_data),
    .wt_wr_en       (cdma2buf_wt_wr_en),
    .wt_wr_addr     (cdma2buf_wt_wr_addr),
    .wt_wr_data     (cdma2buf_wt_wr_data),
    .bank_wr_en     (bank_wr_en),
    .bank_wr_row    (bank_wr_row),
    .bank_wr_data   (bank_wr_data)
  );

  cbuf_read_decode #(
    .NUM_BANKS       (NUM_BANKS),
    .BANK_DEPTH_BITS (BANK_DEPTH_BITS)
  ) u_dat_rd_decode (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .rd_en          (sc2buf_dat_rd_en),
    .rd_addr        (sc2buf_dat_rd_addr),
    .bank_rd_en     (dat_bank_rd_en),
    .bank_rd_row    (dat_bank_rd_row),
    .bank_sel_d2    (dat_bank_sel_d2)
  );

  cbuf_read_decode #(
    .NUM_BANKS       (NUM_BANKS),
    .BANK_DEPTH_BITS (BANK_DEPTH_BITS)
  ) u_wt_rd_decode (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .rd_en          (sc2buf_wt_rd_en),
    .rd_addr        (sc2buf_wt_rd_addr),
    .bank_rd_en     (wt_bank_rd_en),
    .bank_rd_row    (wt_bank_rd_row),
    .bank_sel_d2    (wt_bank_sel_d2)
  );

  cbuf_bank_array #(
    .NUM_BANKS       (NUM_BANKS),
    .BANK_DEPTH_BITS (BANK_DEPTH_BITS)
  ) u_bank_array (
    .nvdla_core_clk  (nvdla_core_clk),
    .rst_n           (rst_n),
    .dat_bank_rd_en  (dat_bank_rd_en),
    .dat_bank_rd_row (dat_bank_rd_row),
    .wt_bank_rd_en   (wt_bank_rd_en),
    .wt_bank_rd_row  (wt_bank_rd_row),
    .bank_wr_en      (bank_wr_en),
    .bank_wr_row     (bank_wr_row),
    .bank_wr_data    (bank_wr_data),
    .bank_rd_data    (bank_rd_data)
  );

  cbuf_read_collect #(
    .NUM_BANKS (NUM_BANKS)
  ) u_dat_rd_collect (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .bank_sel_d2    (dat_bank_sel_d2),
    .bank_rd_data   (bank_rd_data),
    .rd_valid       (sc2buf_dat_rd_valid),
    .rd_data        (sc2buf_dat_rd_data)
  );

  cbuf_read_collect #(
    .NUM_BANKS (NUM_BANKS)
  ) u_wt_rd_collect (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .bank_sel_d2    (wt_bank_sel_d2),
    .bank_rd_data   (bank_rd_data),
    .rd_valid       (sc2buf_wt_rd_valid),
    .rd_data        (sc2buf_wt_rd_data)
  );

endmodule

// File: tb_cbuf_tests.svh
// ==================================================
// directed tests, included inside tb_cbuf
// each test ends with enables low and no read pending
// ==================================================

// valids stay low through reset and while idle after it
task automatic test_reset_quiet();
  test_name = "reset_quiet";
  repeat (RESET_CYCLES - 1) begin
    @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    check_equal("data valid in reset", 64'd0, 64'(sc2buf_dat_rd_valid));
    check_equal("weight valid in reset", 64'd0, 64'(sc2buf_wt_rd_valid));
  end
  @(posedge nvdla_core_clk);
  rst_n <= 1'b1;
  // monitor flags any valid from here on
  idle(10);
endtask

// fill every address through one client, read all back on the same client
task automatic test_round_trip(input int c, input string name);
  test_name = name;
  for (int a = 0; a < NUM_ADDR; a++) begin
    step();
    put_write(c, ADDR_W'(a), next_word());
  end
  idle(3);
  for (int a = 0; a < NUM_ADDR; a++) begin
    step();
    get_read(c, ADDR_W'(a));
  end
  drain();
endtask

// both writers busy each cycle on different banks
// then each client reads back what the other wrote
task automatic test_shared_storage();
  int bank;
  int row;
  test_name = "shared_storage";
  // data gets even rows, weight odd rows, banks two apart
  for (int i = 0; i < NUM_ADDR / 2; i++) begin
    bank = i % NUM_BANKS;
    row  = (i / NUM_BANKS) * 2;
    step();
    put_write(0, make_addr(bank, row), next_word());
    put_write(1, make_addr(bank ^ 2, row + 1), next_word());
  end
  idle(3);
  for (int i = 0; i < NUM_ADDR / 2; i++) begin
    bank = i % NUM_BANKS;
    row  = (i / NUM_BANKS) * 2;
    step();
    get_read(0, make_addr(bank ^ 2, row + 1));
    get_read(1, make_addr(bank, row));
  end
  drain();
endtask

// back to back reads on both clients, several in flight
task automatic test_concurrent_reads();
  int r;
  int dat_bank;
  int wt_bank;
  test_name = "concurrent_reads";
  for (int i = 0; i < 40; i++) begin
    r        = $random(seed);
    dat_bank = r & 3;
    // weight lands one to three banks further, never on the data bank
    wt_bank  = (dat_bank + 1 + (((r >> 2) & 3) % 3)) % NUM_BANKS;
    step();
    // occasional idle slot, which must produce no valid
    if (i % 7 != 6) begin
      get_read(0, make_addr(dat_bank, (r >> 4) & 15));
    end
    if (i % 5 != 4) begin
      get_read(1, make_addr(wt_bank, (r >> 8) & 15));
    end
  end
  drain();
endtask

// overwrite one address, read in the write cycle and 3 cycles later
task automatic test_write_to_read();
  logic [ADDR_W-1:0] addr;
  test_name = "write_to_read";
  addr = ADDR_W'($random(seed));
  step();
  // read queued before the reference update, so it expects the old word
  get_read(1, addr);
  put_write(0, addr, next_word());
  idle(2);
  step();
  // third cycle after the write sees the new word
  get_read(0, addr);
  drain();
endtask

// File: tb_cbuf.sv
// ==================================================
// testbench for cbuf_top at default geometry
// 4 banks of 16 rows, read valid 4 cycles after request
// a read too soon after a write to its address sees the old word
// ==================================================
`timescale 1ns/1ps

module tb_cbuf;

  localparam int NUM_BANKS    = 4;
  localparam int ROWS         = 16;
  localparam int ADDR_W       = 6;
  localparam int NUM_ADDR     = 1 << ADDR_W;
  localparam int RESET_CYCLES = 16;
  // registered control, RAM, masked flop, one tree level
  localparam int RD_LATENCY   = 4;
  // all tests together run well under 600 cycles
  localparam int TIMEOUT_CYCLES = 1500;

  logic                      nvdla_core_clk;
  logic                      rst_n;
  logic                      cdma2buf_dat_wr_en;
  logic [ADDR_W-1:0]         cdma2buf_dat_wr_addr;
  cbuf_geom_pkg::cbuf_data_t cdma2buf_dat_wr_data;
  logic                      cdma2buf_wt_wr_en;
  logic [ADDR_W-1:0]         cdma2buf_wt_wr_addr;
  cbuf_geom_pkg::cbuf_data_t cdma2buf_wt_wr_data;
  logic                      sc2buf_dat_rd_en;
  logic [ADDR_W-1:0]         sc2buf_dat_rd_addr;
  logic                      sc2buf_dat_rd_valid;
  cbuf_geom_pkg::cbuf_data_t sc2buf_dat_rd_data;
  logic                      sc2buf_wt_rd_en;
  logic [ADDR_W-1:0]         sc2buf_wt_rd_addr;
  logic                      sc2buf_wt_rd_valid;
  cbuf_geom_pkg::cbuf_data_t sc2buf_wt_rd_data;

  integer seed = 32'h4a18;
  int     cyc = 0;
  string  test_name = "none";

  // reference contents, indexed by full address
  cbuf_geom_pkg::cbuf_data_t ref_mem [NUM_ADDR];
  // expected reads per client, 0 is data and 1 is weight
  cbuf_geom_pkg::cbuf_data_t exp_data [2][$];
  int                        exp_due  [2][$];

  cbuf_top u_dut (
    .nvdla_core_clk       (nvdla_core_clk),
    .rst_n                (rst_n),
    .cdma2buf_dat_wr_en   (cdma2buf_dat_wr_en),
    .cdma2buf_dat_wr_addr (cdma2buf_dat_wr_addr),
    .cdma2buf_dat_wr_data (cdma2buf_dat_wr_data),
    .cdma2buf_wt_wr_en    (cdma2buf_wt_wr_en),
    .cdma2buf_wt_wr_addr  (cdma2buf_wt_wr_addr),
    .cdma2buf_wt_wr_data  (cdma2buf_wt_wr_data),
    .sc2buf_dat_rd_en     (sc2buf_dat_rd_en),
    .sc2buf_dat_rd_addr   (sc2buf_dat_rd_addr),
    .sc2buf_dat_rd_valid  (sc2buf_dat_rd_valid),
    .sc2buf_dat_rd_data   (sc2buf_dat_rd_data),
    .sc2buf_wt_rd_en      (sc2buf_wt_rd_en),
    .sc2buf_wt_rd_addr    (sc2buf_wt_rd_addr),
    .sc2buf_wt_rd_valid   (sc2buf_wt_rd_valid),
    .sc2buf_wt_rd_data    (sc2buf_wt_rd_data)
  );

  // 4 ns clock
  initial begin
    nvdla_core_clk = 1'b0;
    forever begin
      #2 nvdla_core_clk = ~nvdla_core_clk;
    end
  end

  // ==================================================
  // failure reporting and checks
  // ==================================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped at cycle %0d", cyc);
  endtask

  task automatic check_equal(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("MISMATCH %s %s expected %h actual %h",
                          test_name, what, expected, actual));
    end
  endtask

  // cycle number counts edges, cycle n starts at edge n
  always @(posedge nvdla_core_clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout, the tests did not end within %0d cycles",
                          TIMEOUT_CYCLES));
    end
  end

  // compare one client's read output against its queue
  task automatic watch_client(input int c, input logic valid,
                              input cbuf_geom_pkg::cbuf_data_t data);
    int                        due;
    cbuf_geom_pkg::cbuf_data_t exp_word;
    if ($isunknown(valid)) begin
      abort_run($sformatf("read valid of client %0d is unknown at cycle %0d", c, cyc));
    end else if (valid) begin
      if (exp_due[c].size() == 0) begin
        abort_run($sformatf("client %0d read valid at cycle %0d with no request pending",
                            c, cyc));
      end else begin
        due      = exp_due[c].pop_front();
        exp_word = exp_data[c].pop_front();
        check_equal("valid cycle", 64'(due), 64'(cyc));
        check_equal("read data", exp_word, data);
      end
    end else if (exp_due[c].size() != 0 && exp_due[c][0] < cyc) begin
      abort_run($sformatf("client %0d read valid missing, it was due at cycle %0d",
                          c, exp_due[c][0]));
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge nvdla_core_clk) begin
    if (rst_n) begin
      watch_client(0, sc2buf_dat_rd_valid, sc2buf_dat_rd_data);
      watch_client(1, sc2buf_wt_rd_valid, sc2buf_wt_rd_data);
    end
  end

  // ==================================================
  // drive helpers, called right after a rising edge
  // ==================================================
  // enables drop unless a later call in this step raises them
  task automatic step();
    @(posedge nvdla_core_clk);
    cdma2buf_dat_wr_en <= 1'b0;
    cdma2buf_wt_wr_en  <= 1'b0;
    sc2buf_dat_rd_en   <= 1'b0;
    sc2buf_wt_rd_en    <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  function automatic cbuf_geom_pkg::cbuf_data_t next_word();
    next_word = {$random(seed), $random(seed)};
  endfunction

  function automatic logic [ADDR_W-1:0] make_addr(input int bank, input int row);
    make_addr = ADDR_W'(bank * ROWS + row);
  endfunction

  task automatic put_write(input int c, input logic [ADDR_W-1:0] addr,
                           input cbuf_geom_pkg::cbuf_data_t data);
    if (c == 0) begin
      cdma2buf_dat_wr_en   <= 1'b1;
      cdma2buf_dat_wr_addr <= addr;
      cdma2buf_dat_wr_data <= data;
    end else begin
      cdma2buf_wt_wr_en   <= 1'b1;
      cdma2buf_wt_wr_addr <= addr;
      cdma2buf_wt_wr_data <= data;
    end
    ref_mem[addr] = data;
  endtask

  task automatic get_read(input int c, input logic [ADDR_W-1:0] addr);
    if (c == 0) begin
      sc2buf_dat_rd_en   <= 1'b1;
      sc2buf_dat_rd_addr <= addr;
    end else begin
      sc2buf_wt_rd_en   <= 1'b1;
      sc2buf_wt_rd_addr <= addr;
    end
    // the request occupies the cycle starting at this edge
    exp_due[c].push_back(cyc + 1 + RD_LATENCY);
    exp_data[c].push_back(ref_mem[addr]);
  endtask

  // wait for every pending read, then two quiet cycles
  task automatic drain();
    while (exp_due[0].size() != 0 || exp_due[1].size() != 0) begin
      step();
    end
    idle(2);
  endtask

  `include "tb_cbuf_tests.svh"

  initial begin
    rst_n                = 1'b0;
    cdma2buf_dat_wr_en   = 1'b0;
    cdma2buf_dat_wr_addr = '0;
    cdma2buf_dat_wr_data = '0;
    cdma2buf_wt_wr_en    = 1'b0;
    cdma2buf_wt_wr_addr  = '0;
    cdma2buf_wt_wr_data  = '0;
    sc2buf_dat_rd_en     = 1'b0;
    sc2buf_dat_rd_addr   = '0;
    sc2buf_wt_rd_en      = 1'b0;
    sc2buf_wt_rd_addr    = '0;

    test_reset_quiet();
    test_round_trip(0, "dat_round_trip");
    test_round_trip(1, "wt_round_trip");
    test_shared_storage();
    test_concurrent_reads();
    test_write_to_read();
    idle(4);

    if (exp_due[0].size() != 0 || exp_due[1].size() != 0) begin
      abort_run("reads were still pending when the tests ended");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: project.f
+incdir+.
cbuf_geom_pkg.sv
cbuf_client_pkg.sv
cbuf_bank_ram.sv
cbuf_write_path.sv
cbuf_read_decode.sv
cbuf_bank_array.sv
cbuf_read_collect.sv
cbuf_top.sv
tb_cbuf.sv

// File: run.sh
#!/bin/sh
# build tb_cbuf with Verilator and run it
# pass only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_cbuf -f project.f -o tb_cbuf_sim \
  && ./obj_dir/tb_cbuf_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"

grep -qx "Everything OK" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
